// File: Bender.yml
package:
  name: elevator_display

dependencies: {}

sources:
  - files:
      - hw/elevator_display_pkg.sv
      - hw/shaft_painter.sv
      - hw/scene_compositor.sv
      - hw/palette_out.sv
      - hw/elevator_display.sv
  - target: test
    files:
      - verif/elevator_display_tb.sv

// File: elevator_display.f
hw/elevator_display_pkg.sv
hw/shaft_painter.sv
hw/scene_compositor.sv
hw/palette_out.sv
hw/elevator_display.sv
verif/elevator_display_tb.sv

// File: hw/elevator_display.sv
module elevator_display #(
    parameter int h_active        = 640,
    parameter int v_active        = 480,
    parameter int side_buffer     = 20,
    parameter int top_buffer      = 15,
    parameter int floor_height    = 75,
    parameter int building_width  = 175,
    parameter int outline_width   = 10,
    parameter int shaft_width     = 90,
    parameter int idle_car_height = 70,
    parameter int stop_left       = 300,
    parameter int stop_right      = 340,
    parameter int stop_top        = 200,
    parameter int stop_bottom     = 260
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               enable,
    input  elevator_display_pkg::pixel_pos_t   pos,
    input  elevator_display_pkg::sim_state_t   sim_state,
    input  elevator_display_pkg::destination_t destination,
    output elevator_display_pkg::rgb_t         rgb
);

    elevator_display_pkg::color_id_t left_shaft_color;
    elevator_display_pkg::color_id_t right_shaft_color;
    elevator_display_pkg::color_id_t pixel_color;

    shaft_painter #(
        .v_active        (v_active),
        .top_buffer      (top_buffer),
        .floor_height    (floor_height),
        .idle_car_height (idle_car_height),
        .stop_left       (stop_left),
        .stop_right      (stop_right),
        .stop_top        (stop_top),
        .stop_bottom     (stop_bottom)
    ) u_left_shaft (
        .pos         (pos),
        .sim_state   (sim_state),
        .level       (destination.left_level),
        .shaft_color (left_shaft_color)
    );

    shaft_painter #(
        .v_active        (v_active),
        .top_buffer      (top_buffer),
        .floor_height    (floor_height),
        .idle_car_height (idle_car_height),
        .stop_left       (stop_left),
        .stop_right      (stop_right),
        .stop_top        (stop_top),
        .stop_bottom     (stop_bottom)
    ) u_right_shaft (
        .pos         (pos),
        .sim_state   (sim_state),
        .level       (destination.right_level),
        .shaft_color (right_shaft_color)
    );

    scene_compositor #(
        .h_active       (h_active),
        .v_active       (v_active),
        .side_buffer    (side_buffer),
        .top_buffer     (top_buffer),
        .floor_height   (floor_height),
        .building_width (building_width),
        .outline_width  (outline_width),
        .shaft_width    (shaft_width)
    ) u_scene_compositor (
        .pos               (pos),
        .left_shaft_color  (left_shaft_color),
        .right_shaft_color (right_shaft_color),
        .pixel_color       (pixel_color)
    );

    palette_out u_palette_out (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (enable),
        .pixel_color (pixel_color),
        .rgb         (rgb)
    );

endmodule

// File: hw/elevator_display_pkg.sv
package elevator_display_pkg;

    // Screen coordinate, wide enough for 640x480
    typedef logic [9:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pixel_pos_t;

    // Half-floor steps above ground, 10 and up is the top floor
    typedef logic [3:0] level_t;

    // Left shaft sits in the upper nibble
    typedef struct packed {
        level_t left_level;
        level_t right_level;
    } destination_t;

    // Encoding 3 is unused and drawn as stop
    typedef enum logic [1:0] {
        sim_idle   = 2'd0,
        sim_moving = 2'd1,
        sim_stop   = 2'd2
    } sim_state_t;

    typedef enum logic [2:0] {
        c_sky         = 3'd0,
        c_floor_dark  = 3'd1,
        c_floor_light = 3'd2,
        c_black       = 3'd3,
        c_shaft_bg    = 3'd4,
        c_car         = 3'd5,
        c_stop        = 3'd6,
        c_grass       = 3'd7
    } color_id_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // Colour table
    function automatic rgb_t palette_rgb(input color_id_t color);
        rgb_t value;
        case (color)
            c_sky:         value = '{r: 4'd2,  g: 4'd8,  b: 4'd15};
            c_floor_dark:  value = '{r: 4'd9,  g: 4'd10, b: 4'd10};
            c_floor_light: value = '{r: 4'd11, g: 4'd11, b: 4'd11};
            c_black:       value = '{r: 4'd0,  g: 4'd0,  b: 4'd0};
            c_shaft_bg:    value = '{r: 4'd8,  g: 4'd4,  b: 4'd1};
            c_car:         value = '{r: 4'd4,  g: 4'd4,  b: 4'd4};
            c_stop:        value = '{r: 4'd15, g: 4'd0,  b: 4'd0};
            c_grass:       value = '{r: 4'd0,  g: 4'd15, b: 4'd0};
            default:       value = '0;
        endcase
        return value;
    endfunction

endpackage

// File: hw/palette_out.sv
module palette_out (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            enable,
    input  elevator_display_pkg::color_id_t pixel_color,
    output elevator_display_pkg::rgb_t      rgb
);

    elevator_display_pkg::rgb_t rgb_next;

    // Blank outside the active area
    always_comb begin
        if (enable) begin
            rgb_next = elevator_display_pkg::palette_rgb(pixel_color);
        end else begin
            rgb_next = '0;
        end
    end

    // One pixel of latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rgb <= '0;
        end else begin
            rgb <= rgb_next;
        end
    end

endmodule

// File: hw/scene_compositor.sv
module scene_compositor #(
    parameter int h_active       = 640,
    parameter int v_active       = 480,
    parameter int side_buffer    = 20,
    parameter int top_buffer     = 15,
    parameter int floor_height   = 75,
    parameter int building_width = 175,
    parameter int outline_width  = 10,
    parameter int shaft_width    = 90
) (
    input  elevator_display_pkg::pixel_pos_t pos,
    input  elevator_display_pkg::color_id_t  left_shaft_color,
    input  elevator_display_pkg::color_id_t  right_shaft_color,
    output elevator_display_pkg::color_id_t  pixel_color
);

    // Column edges, each region starts where the previous one ends
    localparam int left_bldg_end     = side_buffer + building_width;
    localparam int left_outline_end  = left_bldg_end + outline_width;
    localparam int left_shaft_end    = left_outline_end + shaft_width;
    localparam int mid_outline_end   = left_shaft_end + outline_width;
    localparam int right_shaft_end   = mid_outline_end + shaft_width;
    localparam int right_outline_end = right_shaft_end + outline_width;
    localparam int right_bldg_end    = h_active - side_buffer;

    localparam int shaft_bottom = v_active - top_buffer;
    localparam int num_floors   = (v_active - 2 * top_buffer) / floor_height;

    int   band;
    logic band_light;
    logic in_left_bldg;
    logic in_right_bldg;
    logic in_shaft_rows;
    logic in_right_sky;

    // Floor band index, the last band runs to the bottom of the screen
    always_comb begin
        band = 0;
        for (int i = 1; i < num_floors; i++) begin
            if (pos.y >= top_buffer + i * floor_height) begin
                band = i;
            end
        end
    end

    // Band 0 is dark, then alternating, and the ground floor is always light
    assign band_light = (band == num_floors - 1) || band[0];

    assign in_left_bldg  = (pos.x >= side_buffer) && (pos.x < left_bldg_end);
    assign in_right_bldg = (pos.x >= right_outline_end) && (pos.x < right_bldg_end);
    assign in_shaft_rows = (pos.y >= top_buffer) && (pos.y < shaft_bottom);

    assign in_right_sky = (pos.x >= right_bldg_end) && (pos.x < h_active) &&
                          (pos.y < shaft_bottom);

    always_comb begin
        if (pos.x < side_buffer) begin
            pixel_color = elevator_display_pkg::c_sky;
        end else if (in_right_sky) begin
            pixel_color = elevator_display_pkg::c_sky;
        end else if (pos.y < top_buffer) begin
            pixel_color = elevator_display_pkg::c_sky;
        end else if (in_left_bldg || in_right_bldg) begin
            if (band_light) begin
                pixel_color = elevator_display_pkg::c_floor_light;
            end else begin
                pixel_color = elevator_display_pkg::c_floor_dark;
            end
        end else if (in_shaft_rows && (pos.x >= left_bldg_end) &&
                     (pos.x < left_outline_end)) begin
            pixel_color = elevator_display_pkg::c_black;
        end else if (in_shaft_rows && (pos.x >= left_outline_end) &&
                     (pos.x < left_shaft_end)) begin
            pixel_color = left_shaft_color;
        end else if (in_shaft_rows && (pos.x >= left_shaft_end) &&
                     (pos.x < mid_outline_end)) begin
            // Middle outline hides the left part of the stop box
            pixel_color = elevator_display_pkg::c_black;
        end else if (in_shaft_rows && (pos.x >= mid_outline_end) &&
                     (pos.x < right_shaft_end)) begin
            pixel_color = right_shaft_color;
        end else if (in_shaft_rows && (pos.x >= right_shaft_end) &&
                     (pos.x < right_outline_end)) begin
            pixel_color = elevator_display_pkg::c_black;
        end else begin
            // Below the shafts and past the visible width
            pixel_color = elevator_display_pkg::c_grass;
        end
    end

endmodule

// File: hw/shaft_painter.sv
module shaft_painter #(
    parameter int v_active        = 480,
    parameter int top_buffer      = 15,
    parameter int floor_height    = 75,
    parameter int idle_car_height = 70,
    parameter int stop_left       = 300,
    parameter int stop_right      = 340,
    parameter int stop_top        = 200,
    parameter int stop_bottom     = 260
) (
    input  elevator_display_pkg::pixel_pos_t pos,
    input  elevator_display_pkg::sim_state_t sim_state,
    input  elevator_display_pkg::level_t     level,
    output elevator_display_pkg::color_id_t  shaft_color
);

    localparam int shaft_bottom = v_active - top_buffer;
    localparam int idle_top     = shaft_bottom - idle_car_height;
    localparam int top_level    = 10;

    elevator_display_pkg::level_t level_capped;
    elevator_display_pkg::coord_t car_bottom;
    elevator_display_pkg::coord_t car_top;
    logic                         in_idle_car;
    logic                         in_moving_car;
    logic                         in_stop_box;

    // Car position, half a floor per level step
    always_comb begin
        if (level > elevator_display_pkg::level_t'(top_level)) begin
            level_capped = elevator_display_pkg::level_t'(top_level);
        end else begin
            level_capped = level;
        end
        car_bottom = elevator_display_pkg::coord_t'(
            shaft_bottom - (int'(level_capped) * floor_height) / 2);
        car_top = elevator_display_pkg::coord_t'(int'(car_bottom) - floor_height);
    end

    assign in_idle_car   = (pos.y >= idle_top) && (pos.y < shaft_bottom);
    assign in_moving_car = (pos.y >= car_top) && (pos.y < car_bottom);

    // Stop box is in screen coordinates, shared by both shafts
    assign in_stop_box = (pos.x >= stop_left) && (pos.x < stop_right) &&
                         (pos.y >= stop_top) && (pos.y < stop_bottom);

    always_comb begin
        case (sim_state)
            elevator_display_pkg::sim_idle: begin
                if (in_idle_car) begin
                    shaft_color = elevator_display_pkg::c_car;
                end else begin
                    shaft_color = elevator_display_pkg::c_shaft_bg;
                end
            end
            elevator_display_pkg::sim_moving: begin
                if (in_moving_car) begin
                    shaft_color = elevator_display_pkg::c_car;
                end else begin
                    shaft_color = elevator_display_pkg::c_shaft_bg;
                end
            end
            default: begin
                // Stop, also for the spare encoding
                if (in_stop_box) begin
                    shaft_color = elevator_display_pkg::c_stop;
                end else begin
                    shaft_color = elevator_display_pkg::c_black;
                end
            end
        endcase
    end

endmodule

// File: verif/elevator_display_tb.sv
module elevator_display_tb;

    // Scene geometry of the top-level build
    localparam int shaft_bottom = 465;
    localparam int idle_top     = 395;
    localparam int floor_height = 75;
    localparam int top_buffer   = 15;

    // Tests take about 2300 cycles and streaming is most of them
    localparam int cycle_limit = 6000;

    logic                               clk;
    logic                               rst_n;
    logic                               enable;
    elevator_display_pkg::pixel_pos_t   pos;
    elevator_display_pkg::sim_state_t   sim_state;
    elevator_display_pkg::destination_t destination;
    elevator_display_pkg::rgb_t         rgb;

    int                                 error_count;
    int                                 check_count;
    int                                 cycle_count;
    logic [15:0]                        lfsr_state;
    elevator_display_pkg::rgb_t         prev_rgb;
    elevator_display_pkg::pixel_pos_t   prev_pos;

    elevator_display u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (enable),
        .pos         (pos),
        .sim_state   (sim_state),
        .destination (destination),
        .rgb         (rgb)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 16'hB400;
        end
        return next;
    endfunction

    function automatic logic [9:0] take_bits(input int count);
        logic [9:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[8:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    function automatic elevator_display_pkg::pixel_pos_t make_pos(input int x, input int y);
        elevator_display_pkg::pixel_pos_t p;
        p.x = elevator_display_pkg::coord_t'(x);
        p.y = elevator_display_pkg::coord_t'(y);
        return p;
    endfunction

    function automatic elevator_display_pkg::destination_t make_dest(input int l, input int r);
        elevator_display_pkg::destination_t d;
        d.left_level  = elevator_display_pkg::level_t'(l);
        d.right_level = elevator_display_pkg::level_t'(r);
        return d;
    endfunction

    function automatic elevator_display_pkg::color_id_t shaft_model(
        input elevator_display_pkg::pixel_pos_t p,
        input elevator_display_pkg::sim_state_t st,
        input elevator_display_pkg::level_t     lvl
    );
        int x;
        int y;
        int capped;
        int bottom;
        x = p.x;
        y = p.y;
        if (st == elevator_display_pkg::sim_idle) begin
            if (y >= idle_top && y < shaft_bottom) begin
                return elevator_display_pkg::c_car;
            end
            return elevator_display_pkg::c_shaft_bg;
        end else if (st == elevator_display_pkg::sim_moving) begin
            capped = (lvl > 10) ? 10 : lvl;
            bottom = shaft_bottom - (capped * floor_height) / 2;
            if (y >= bottom - floor_height && y < bottom) begin
                return elevator_display_pkg::c_car;
            end
            return elevator_display_pkg::c_shaft_bg;
        end
        if (x >= 300 && x < 340 && y >= 200 && y < 260) begin
            return elevator_display_pkg::c_stop;
        end
        return elevator_display_pkg::c_black;
    endfunction

    function automatic elevator_display_pkg::color_id_t scene_model(
        input elevator_display_pkg::pixel_pos_t   p,
        input elevator_display_pkg::sim_state_t   st,
        input elevator_display_pkg::destination_t d
    );
        int x;
        int y;
        int band;
        x = p.x;
        y = p.y;
        if (x < 20 || (x >= 620 && x < 640 && y < shaft_bottom) || y < top_buffer) begin
            return elevator_display_pkg::c_sky;
        end
        if ((x >= 20 && x < 195) || (x >= 405 && x < 620)) begin
            band = (y - top_buffer) / floor_height;
            if (band >= 5) begin
                return elevator_display_pkg::c_floor_light;
            end
            return (band % 2 == 1) ? elevator_display_pkg::c_floor_light :
                                     elevator_display_pkg::c_floor_dark;
        end
        if (y < shaft_bottom && x >= 195 && x < 405) begin
            if (x >= 205 && x < 295) begin
                return shaft_model(p, st, d.left_level);
            end
            if (x >= 305 && x < 395) begin
                return shaft_model(p, st, d.right_level);
            end
            return elevator_display_pkg::c_black;
        end
        return elevator_display_pkg::c_grass;
    endfunction

    task automatic check_rgb(
        input elevator_display_pkg::rgb_t       expected,
        input elevator_display_pkg::rgb_t       actual,
        input elevator_display_pkg::pixel_pos_t p,
        input string                            what
    );
        check_count = check_count + 1;
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("[FAIL] t=%0t %s at (%0d,%0d): expected %h, got %h",
                     $time, what, p.x, p.y, expected, actual);
        end
    endtask

    // Called at a falling edge, returns at the next one
    task automatic drive_pixel(
        input logic                               en,
        input elevator_display_pkg::pixel_pos_t   p,
        input elevator_display_pkg::sim_state_t   st,
        input elevator_display_pkg::destination_t d
    );
        elevator_display_pkg::rgb_t want;
        enable      = en;
        pos         = p;
        sim_state   = st;
        destination = d;
        #1;
        check_rgb(prev_rgb, rgb, prev_pos, "output changed before the clock edge");
        if (en) begin
            want = elevator_display_pkg::palette_rgb(scene_model(p, st, d));
        end else begin
            want = '0;
        end
        @(negedge clk);
        check_rgb(want, rgb, p, "pixel colour");
        prev_rgb = want;
        prev_pos = p;
    endtask

    task automatic show_pixel(
        input int                                 x,
        input int                                 y,
        input elevator_display_pkg::sim_state_t   st,
        input elevator_display_pkg::destination_t d
    );
        drive_pixel(1'b1, make_pos(x, y), st, d);
    endtask

    task automatic report_test(input string name, input int checks_at, input int errors_at);
        $display("Test %s finished: %0d checks, %0d errors",
                 name, check_count - checks_at, error_count - errors_at);
    endtask

    task automatic test_reset_blanking();
        int c0;
        int e0;
        c0 = check_count;
        e0 = error_count;
        repeat (5) begin
            @(negedge clk);
            check_rgb('0, rgb, pos, "output during reset");
        end
        rst_n = 1'b1;
        drive_pixel(1'b0, make_pos(100, 100), elevator_display_pkg::sim_idle, make_dest(0, 0));
        drive_pixel(1'b0, make_pos(250, 420), elevator_display_pkg::sim_idle, make_dest(0, 0));
        drive_pixel(1'b1, make_pos(5, 5), elevator_display_pkg::sim_idle, make_dest(0, 0));
        drive_pixel(1'b0, make_pos(5, 5), elevator_display_pkg::sim_idle, make_dest(0, 0));
        drive_pixel(1'b1, make_pos(500, 300), elevator_display_pkg::sim_stop, make_dest(3, 7));
        // Asynchronous clear while the clock is low
        rst_n = 1'b0;
        #1;
        check_rgb('0, rgb, pos, "output right after reset fell");
        @(negedge clk);
        check_rgb('0, rgb, pos, "output while held in reset");
        rst_n    = 1'b1;
        prev_rgb = '0;
        drive_pixel(1'b1, make_pos(630, 100), elevator_display_pkg::sim_idle, make_dest(0, 0));
        report_test("reset_blanking", c0, e0);
    endtask

    task automatic test_static_scene();
        int edge_x[12] = '{194, 195, 204, 205, 294, 295, 304, 305, 394, 395, 404, 405};
        int corner_x[7] = '{0, 639, 0, 639, 10, 630, 630};
        int corner_y[7] = '{0, 0, 479, 479, 300, 464, 465};
        int c0;
        int e0;
        elevator_display_pkg::destination_t d;
        c0 = check_count;
        e0 = error_count;
        d = make_dest(0, 0);
        for (int i = 0; i < 7; i++) begin
            show_pixel(corner_x[i], corner_y[i], elevator_display_pkg::sim_idle, d);
        end
        for (int i = 0; i < 6; i++) begin
            show_pixel(100, top_buffer + floor_height * i, elevator_display_pkg::sim_idle, d);
            show_pixel(100, top_buffer + floor_height * i + 74, elevator_display_pkg::sim_idle, d);
            show_pixel(500, top_buffer + floor_height * i, elevator_display_pkg::sim_idle, d);
            show_pixel(500, top_buffer + floor_height * i + 74, elevator_display_pkg::sim_idle, d);
        end
        for (int i = 0; i < 12; i++) begin
            show_pixel(edge_x[i], 100, elevator_display_pkg::sim_idle, d);
        end
        show_pixel(20, 479, elevator_display_pkg::sim_idle, d);
        show_pixel(194, 479, elevator_display_pkg::sim_idle, d);
        show_pixel(405, 479, elevator_display_pkg::sim_idle, d);
        show_pixel(619, 479, elevator_display_pkg::sim_idle, d);
        show_pixel(250, 14, elevator_display_pkg::sim_idle, d);
        show_pixel(250, 470, elevator_display_pkg::sim_idle, d);
        show_pixel(300, 465, elevator_display_pkg::sim_idle, d);
        show_pixel(350, 479, elevator_display_pkg::sim_idle, d);
        show_pixel(640, 100, elevator_display_pkg::sim_idle, d);
        show_pixel(700, 300, elevator_display_pkg::sim_idle, d);
        show_pixel(1023, 20, elevator_display_pkg::sim_idle, d);
        report_test("static_scene", c0, e0);
    endtask

    task automatic test_idle_car();
        int rows[5] = '{300, 394, 395, 464, 465};
        int c0;
        int e0;
        c0 = check_count;
        e0 = error_count;
        for (int i = 0; i < 5; i++) begin
            show_pixel(250, rows[i], elevator_display_pkg::sim_idle, make_dest(5, 10));
            show_pixel(350, rows[i], elevator_display_pkg::sim_idle, make_dest(12, 2));
        end
        report_test("idle_car", c0, e0);
    endtask

    task automatic test_moving_car();
        int x;
        int l;
        int capped;
        int bottom;
        int top;
        int c0;
        int e0;
        elevator_display_pkg::destination_t d;
        c0 = check_count;
        e0 = error_count;
        for (int lvl = 0; lvl < 16; lvl++) begin
            d = make_dest(lvl, 15 - lvl);
            for (int s = 0; s < 2; s++) begin
                x = (s == 0) ? 250 : 350;
                l = (s == 0) ? lvl : 15 - lvl;
                capped = (l > 10) ? 10 : l;
                bottom = shaft_bottom - (capped * floor_height) / 2;
                top = bottom - floor_height;
                show_pixel(x, top - 1, elevator_display_pkg::sim_moving, d);
                show_pixel(x, top, elevator_display_pkg::sim_moving, d);
                show_pixel(x, bottom - 1, elevator_display_pkg::sim_moving, d);
                show_pixel(x, bottom, elevator_display_pkg::sim_moving, d);
            end
        end
        report_test("moving_car", c0, e0);
    endtask

    task automatic test_stop_state();
        int px[11] = '{310, 339, 340, 320, 320, 300, 304, 305, 250, 250, 350};
        int py[11] = '{210, 259, 230, 199, 260, 230, 230, 230, 230, 400, 100};
        int c0;
        int e0;
        logic [1:0] code;
        elevator_display_pkg::sim_state_t st;
        c0 = check_count;
        e0 = error_count;
        for (int s = 2; s < 4; s++) begin
            code = 2'(s);
            st = elevator_display_pkg::sim_state_t'(code);
            for (int i = 0; i < 11; i++) begin
                show_pixel(px[i], py[i], st, make_dest(4, 9));
            end
        end
        report_test("stop_state", c0, e0);
    endtask

    task automatic test_streaming();
        logic                               en;
        logic [1:0]                         code;
        logic [3:0]                         lvl_bits;
        int                                 x;
        int                                 y;
        int                                 c0;
        int                                 e0;
        elevator_display_pkg::sim_state_t   st;
        elevator_display_pkg::destination_t d;
        c0 = check_count;
        e0 = error_count;
        for (int n = 0; n < 2000; n++) begin
            en = (take_bits(3) != 0);
            code = 2'(take_bits(2));
            st = elevator_display_pkg::sim_state_t'(code);
            lvl_bits = 4'(take_bits(4));
            d.left_level = lvl_bits;
            lvl_bits = 4'(take_bits(4));
            d.right_level = lvl_bits;
            x = take_bits(10) % 680;
            y = take_bits(10) % 480;
            drive_pixel(en, make_pos(x, y), st, d);
        end
        report_test("streaming", c0, e0);
    endtask

    initial begin
        rst_n       = 1'b0;
        enable      = 1'b1;
        pos         = make_pos(100, 100);
        sim_state   = elevator_display_pkg::sim_idle;
        destination = make_dest(0, 0);
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        lfsr_state  = 16'd34069;
        prev_rgb    = '0;
        prev_pos    = make_pos(100, 100);

        test_reset_blanking();
        test_static_scene();
        test_idle_car();
        test_moving_car();
        test_stop_state();
        test_streaming();

        $display("Total: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
